//--- hw/i3c_bus_sequencer.sv
// Write-frame sequencer: START, address, ACK, data, ACK and STOP on open-drain lines
`timescale 1ns/1ps
`include "i3c_cfg.svh"

module i3c_bus_sequencer (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              empty_i,
    input  i3c_pkg::i3c_cmd_t cmd_i,
    input  logic              scl_i,
    input  logic              sda_i,
    output logic              pop_o,
    output logic              scl_o,
    output logic              sda_o,
    output logic              busy_o,
    output logic              done_o,
    output logic              nack_o
);

    import i3c_pkg::*;

    localparam int unsigned DIV   = `I3C_SCL_DIV;
    localparam int unsigned CNT_W = (DIV > 1) ? $clog2(DIV) : 1;
    localparam logic [CNT_W-1:0] LAST = CNT_W'(DIV - 1);
    localparam logic [CNT_W-1:0] MID  = CNT_W'(DIV / 2);

    i3c_seq_state_t   state_q;
    logic [CNT_W-1:0] div_cnt_q;
    logic [2:0]       bit_cnt_q;
    logic             data_phase_q;
    logic             scl_q;
    logic             sda_q;
    logic             nack_q;
    logic [7:0]       shift_q;
    logic [7:0]       data_q;

    logic stretch;
    logic running;
    logic half_end;
    logic low_start;
    logic high_mid;
    logic ack_sample;
    logic ack_bad;
    logic start_frame;

    // Target may still hold SCL low after we release it
    assign stretch  = scl_q && !scl_i;
    assign running  = (state_q != IDLE) && (state_q != DONE);
    assign half_end = running && !stretch && (div_cnt_q == LAST);

    // SDA moves one cycle into the low phase, well clear of the SCL edges
    assign low_start = running && !scl_q && (div_cnt_q == '0);
    assign high_mid  = running && scl_q && !stretch && (div_cnt_q == MID);

    assign ack_sample = (state_q == ACK) && high_mid;
    // Includes a NACK seen in this very cycle
    assign ack_bad    = nack_q || (ack_sample && sda_i);

    assign start_frame = (state_q == IDLE) && !empty_i;

    // Half-period divider, frozen while SCL is stretched
    always_ff @(posedge clk_i) begin
        if (rst_i || !running) begin
            div_cnt_q <= '0;
        end else if (!stretch) begin
            div_cnt_q <= (div_cnt_q == LAST) ? '0 : div_cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q      <= IDLE;
            scl_q        <= 1'b1;
            sda_q        <= 1'b1;
            bit_cnt_q    <= '0;
            data_phase_q <= 1'b0;
            nack_q       <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start_frame) begin
                        // START: SDA falls with SCL high
                        sda_q        <= 1'b0;
                        nack_q       <= 1'b0;
                        data_phase_q <= 1'b0;
                        state_q      <= START;
                    end
                end

                START: begin
                    if (half_end) begin
                        scl_q     <= 1'b0;
                        bit_cnt_q <= 3'd7;
                        state_q   <= BITS;
                    end
                end

                BITS: begin
                    if (low_start) begin
                        sda_q <= shift_q[7];
                    end
                    if (half_end) begin
                        scl_q <= !scl_q;
                        // Falling edge ends a bit
                        if (scl_q) begin
                            if (bit_cnt_q == 3'd0) begin
                                state_q <= ACK;
                            end else begin
                                bit_cnt_q <= bit_cnt_q - 1'b1;
                            end
                        end
                    end
                end

                ACK: begin
                    // Release SDA for the target
                    if (low_start) begin
                        sda_q <= 1'b1;
                    end
                    if (ack_sample) begin
                        nack_q <= ack_bad;
                    end
                    if (half_end) begin
                        scl_q <= !scl_q;
                        if (scl_q) begin
                            if (!data_phase_q && !ack_bad) begin
                                bit_cnt_q    <= 3'd7;
                                data_phase_q <= 1'b1;
                                state_q      <= BITS;
                            end else begin
                                // Address NACK skips the data byte
                                state_q <= STOP;
                            end
                        end
                    end
                end

                STOP: begin
                    if (low_start) begin
                        sda_q <= 1'b0;
                    end
                    if (half_end && !scl_q) begin
                        scl_q <= 1'b1;
                    end
                    // STOP: SDA rises with SCL high
                    if (high_mid) begin
                        sda_q <= 1'b1;
                    end
                    if (half_end && scl_q) begin
                        state_q <= DONE;
                    end
                end

                DONE: begin
                    state_q <= IDLE;
                end

                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // Byte shifter, loaded with the address then the data byte
    always_ff @(posedge clk_i) begin
        if (start_frame) begin
            shift_q <= {cmd_i.addr, 1'b0};
            data_q  <= cmd_i.data;
        end else if ((state_q == ACK) && half_end && scl_q) begin
            shift_q <= data_q;
        end else if ((state_q == BITS) && half_end && scl_q) begin
            shift_q <= {shift_q[6:0], 1'b0};
        end
    end

    assign pop_o  = start_frame;
    assign scl_o  = scl_q;
    assign sda_o  = sda_q;
    assign busy_o = (state_q != IDLE);
    assign done_o = (state_q == DONE);
    assign nack_o = nack_q;

endmodule

//--- hw/i3c_cfg.svh
// Build-time sizes for the command FIFO and the SCL divider
`ifndef I3C_CFG_SVH
`define I3C_CFG_SVH

// Command FIFO entries, a power of two
`define I3C_FIFO_DEPTH 4

// clk_i cycles in each SCL half period
// Keep at 2 or more so SDA can move inside the low phase
`define I3C_SCL_DIV 4

`endif

//--- hw/i3c_cmd_fifo.sv
// Synchronous circular FIFO with a type-parameterized payload
`timescale 1ns/1ps
`include "i3c_cfg.svh"

module i3c_cmd_fifo #(
    parameter type T = logic [7:0]
) (
    input  logic clk_i,
    input  logic rst_i,
    input  logic push_i,
    input  T     push_data_i,
    input  logic pop_i,
    output T     rd_data_o,
    output logic full_o,
    output logic empty_o
);

    localparam int unsigned DEPTH = `I3C_FIFO_DEPTH;
    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(DEPTH);

    T                 mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push_ok;
    logic             pop_ok;

    assign full_o  = (count_q == CNT_FULL);
    assign empty_o = (count_q == '0);

    // Requests against a full or empty buffer are ignored
    assign push_ok = push_i && !full_o;
    assign pop_ok  = pop_i && !empty_o;

    // Head entry always visible
    assign rd_data_o = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (push_ok) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr_q <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr_q <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push_ok, pop_ok})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

//--- hw/i3c_cmd_intake.sv
// Register-write intake that builds commands, pushes them and counts drops
`timescale 1ns/1ps

module i3c_cmd_intake (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   wr_en_i,
    input  logic                   wr_sel_i,
    input  logic [7:0]             wr_data_i,
    input  logic                   full_i,
    output logic                   push_o,
    output i3c_pkg::i3c_cmd_t      push_data_o,
    output i3c_pkg::i3c_drop_cnt_t drop_cnt_o
);

    // Register select encoding
    localparam logic SEL_ADDR = 1'b0;
    localparam logic SEL_DATA = 1'b1;

    logic [6:0] addr_q;
    logic       pend_q;
    logic       addr_wr;
    logic       data_wr;
    logic       drop;

    assign addr_wr = wr_en_i && (wr_sel_i == SEL_ADDR);
    assign data_wr = wr_en_i && (wr_sel_i == SEL_DATA);

    // Push goes out the cycle after the strobe, unless the FIFO is full then
    assign push_o = pend_q && !full_i;
    assign drop   = pend_q && full_i;

    // Target address register
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            addr_q <= '0;
        end else if (addr_wr) begin
            addr_q <= wr_data_i[6:0];
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pend_q <= 1'b0;
        end else begin
            pend_q <= data_wr;
        end
    end

    // Command captured with the address held at strobe time
    always_ff @(posedge clk_i) begin
        if (data_wr) begin
            push_data_o <= '{addr: addr_q, data: wr_data_i};
        end
    end

    // Drop counter sticks at all ones
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            drop_cnt_o <= '0;
        end else if (drop && (drop_cnt_o != '1)) begin
            drop_cnt_o <= drop_cnt_o + 1'b1;
        end
    end

endmodule

//--- hw/i3c_pkg.sv
// Shared types: command payload, drop counter and bus sequencer state
package i3c_pkg;

    // One queued write, address sent before data
    typedef struct packed {
        logic [6:0] addr;
        logic [7:0] data;
    } i3c_cmd_t;

    // Saturating count of writes lost to a full FIFO
    typedef logic [7:0] i3c_drop_cnt_t;

    // Frame sequencing
    typedef enum logic [2:0] {
        IDLE,
        START,
        BITS,
        ACK,
        STOP,
        DONE
    } i3c_seq_state_t;

endpackage

//--- hw/i3c_top.sv
// Top level: command intake, command FIFO, bus sequencer and wired-AND bus lines
`timescale 1ns/1ps

module i3c_top (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   wr_en_i,
    input  logic                   wr_sel_i,
    input  logic [7:0]             wr_data_i,
    input  logic                   scl_sim_target_i,
    input  logic                   sda_sim_target_i,
    output logic                   bus_scl_o,
    output logic                   bus_sda_o,
    output logic                   busy_o,
    output logic                   done_o,
    output logic                   nack_o,
    output i3c_pkg::i3c_drop_cnt_t drop_cnt_o
);

    import i3c_pkg::*;

    // Controller plus one simulated target
    localparam int unsigned NUM_DEVICES = 2;

    i3c_cmd_t push_data;
    i3c_cmd_t rd_data;
    logic     push;
    logic     full;
    logic     pop;
    logic     empty;
    logic     ctrl_scl;
    logic     ctrl_sda;

    logic [NUM_DEVICES-1:0] scl_drv;
    logic [NUM_DEVICES-1:0] sda_drv;

    // Open drain, any device pulling low wins
    assign scl_drv   = {scl_sim_target_i, ctrl_scl};
    assign sda_drv   = {sda_sim_target_i, ctrl_sda};
    assign bus_scl_o = &scl_drv;
    assign bus_sda_o = &sda_drv;

    i3c_cmd_intake xi3c_cmd_intake (
        .clk_i,
        .rst_i,
        .wr_en_i,
        .wr_sel_i,
        .wr_data_i,
        .full_i      (full),
        .push_o      (push),
        .push_data_o (push_data),
        .drop_cnt_o
    );

    i3c_cmd_fifo #(
        .T(i3c_cmd_t)
    ) xi3c_cmd_fifo (
        .clk_i,
        .rst_i,
        .push_i      (push),
        .push_data_i (push_data),
        .pop_i       (pop),
        .rd_data_o   (rd_data),
        .full_o      (full),
        .empty_o     (empty)
    );

    i3c_bus_sequencer xi3c_bus_sequencer (
        .clk_i,
        .rst_i,
        .empty_i (empty),
        .cmd_i   (rd_data),
        .scl_i   (bus_scl_o),
        .sda_i   (bus_sda_o),
        .pop_o   (pop),
        .scl_o   (ctrl_scl),
        .sda_o   (ctrl_sda),
        .busy_o,
        .done_o,
        .nack_o
    );

endmodule

//--- tests/i3c_chk.sv
// Bound assertions on FIFO push/pop and bus protocol rules
`timescale 1ns/1ps

module i3c_chk (
    input logic                   clk_i,
    input logic                   rst_i,
    input logic                   push_i,
    input logic                   full_i,
    input logic                   pop_i,
    input logic                   empty_i,
    input logic                   scl_i,
    input logic                   sda_i,
    input i3c_pkg::i3c_seq_state_t state_i,
    input logic                   done_i
);

    import i3c_pkg::*;

    int err_cnt = 0;

    // Intake must hold back pushes into a full buffer
    assert property (@(posedge clk_i) disable iff (rst_i) !(push_i && full_i))
    else begin
        $error("push while FIFO full");
        err_cnt++;
    end

    assert property (@(posedge clk_i) disable iff (rst_i) pop_i |-> !empty_i)
    else begin
        $error("pop while FIFO empty");
        err_cnt++;
    end

    // Data bits and ACK slots only
    assert property (@(posedge clk_i) disable iff (rst_i)
        (scl_i && $past(scl_i) && (state_i inside {BITS, ACK})
            && ($past(state_i) inside {BITS, ACK})) |-> $stable(sda_i))
    else begin
        $error("SDA moved while SCL high");
        err_cnt++;
    end

    assert property (@(posedge clk_i) disable iff (rst_i) done_i |=> !done_i)
    else begin
        $error("done_o longer than one cycle");
        err_cnt++;
    end

endmodule

bind i3c_cmd_fifo i3c_chk fifo_chk (
    .clk_i, .rst_i, .push_i, .full_i(full_o), .pop_i(1'b0), .empty_i(1'b0),
    .scl_i(1'b0), .sda_i(1'b0), .state_i(i3c_pkg::IDLE), .done_i(1'b0)
);

bind i3c_bus_sequencer i3c_chk seq_chk (
    .clk_i, .rst_i, .push_i(1'b0), .full_i(1'b0), .pop_i(pop_o), .empty_i,
    .scl_i, .sda_i, .state_i(state_q), .done_i(done_o)
);

//--- tests/i3c_tb.sv
// Testbench: clock, reset, random writes, target model, reference queue and checks
`timescale 1ns/1ps
`include "i3c_cfg.svh"

module i3c_tb;

    import i3c_pkg::*;

    localparam logic [6:0] TB_TARGET_ADDR = 7'h2a;
    localparam int         DEPTH          = `I3C_FIFO_DEPTH;

    logic clk_i = 1'b0;
    logic rst_i, wr_en_i, wr_sel_i, scl_sim_target_i, sda_sim_target_i;
    logic [7:0] wr_data_i;
    logic bus_scl_o, bus_sda_o, busy_o, done_o, nack_o;
    i3c_drop_cnt_t drop_cnt_o;

    logic [31:0] lcg_state = 32'h74a83bba;
    int mismatches = 0;
    int failures = 0;
    int occ = 0;
    int drops = 0;
    logic [6:0] cur_addr = '0;
    i3c_cmd_t ref_q[$];
    i3c_cmd_t got_q[$];
    logic had_data_q[$];

    // Target model state
    logic       in_frame = 1'b0;
    logic       scl_prev = 1'b1;
    logic       sda_prev = 1'b1;
    int         bit_cnt, byte_idx;
    logic [7:0] sh;
    logic [6:0] t_addr;
    logic [7:0] t_data;
    logic       t_ack;

    i3c_top i3c_top_inst (.*);

    always #50 clk_i = ~clk_i;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_cmd(string name, i3c_cmd_t got, i3c_cmd_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_nack(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_drops(string name, i3c_drop_cnt_t got, i3c_drop_cnt_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
            mismatches++;
        end
    endtask

    // Register write, model updated as the write is issued
    task automatic write_reg(logic sel, logic [7:0] data);
        @(negedge clk_i);
        wr_en_i   = 1'b1;
        wr_sel_i  = sel;
        wr_data_i = data;
        if (!sel) begin
            cur_addr = data[6:0];
        end else if (occ < DEPTH) begin
            ref_q.push_back('{addr: cur_addr, data: data});
            occ++;
        end else begin
            drops++;
        end
    endtask

    task automatic release_wr();
        @(negedge clk_i);
        wr_en_i = 1'b0;
    endtask

    always @(posedge busy_o) occ--;

    // Bus seen at each falling clock edge, ACK driven and released only while SCL is low
    always @(negedge clk_i) begin
        if (!rst_i) begin
            if (scl_prev && bus_scl_o && sda_prev && !bus_sda_o) begin
                // START
                in_frame = 1'b1;
                bit_cnt  = 0;
                byte_idx = 0;
            end else if (in_frame && scl_prev && bus_scl_o && !sda_prev && bus_sda_o) begin
                // STOP
                in_frame = 1'b0;
                got_q.push_back('{addr: t_addr, data: t_data});
                had_data_q.push_back(byte_idx >= 2);
            end else if (in_frame && !scl_prev && bus_scl_o) begin
                if (bit_cnt < 8) sh = {sh[6:0], bus_sda_o};
                bit_cnt++;
            end else if (in_frame && scl_prev && !bus_scl_o) begin
                if (bit_cnt == 8) begin
                    if (byte_idx == 0) begin
                        t_addr = sh[7:1];
                        t_data = 'x;
                        t_ack  = (t_addr == TB_TARGET_ADDR);
                    end else begin
                        t_data = sh;
                    end
                    sda_sim_target_i = !t_ack;
                end else if (bit_cnt == 9) begin
                    sda_sim_target_i = 1'b1;
                    bit_cnt = 0;
                    byte_idx++;
                end
            end
        end
        scl_prev = bus_scl_o;
        sda_prev = bus_sda_o;
    end

    // Each done_o pulse retires one reference entry
    always @(negedge clk_i) begin
        i3c_cmd_t exp;
        i3c_cmd_t got;
        logic     had_data;
        if (!rst_i && done_o) begin
            if (ref_q.size() == 0 || got_q.size() == 0) begin
                $display("Error at %0t: frame finished with nothing expected or decoded", $time);
                failures++;
            end else begin
                exp = ref_q.pop_front();
                got = got_q.pop_front();
                had_data = had_data_q.pop_front();
                check_nack("nack_o", nack_o, exp.addr != TB_TARGET_ADDR);
                if (exp.addr != TB_TARGET_ADDR) begin
                    got.data = exp.data;
                    if (had_data) begin
                        $display("Error at %0t: data byte sent after address NACK", $time);
                        failures++;
                    end
                end
                check_cmd("frame", got, exp);
            end
        end
    end

    task automatic wait_busy(output logic ok);
        int n;
        for (n = 0; n < 200 && !busy_o; n++) @(negedge clk_i);
        ok = busy_o;
        if (!ok) begin
            $display("Error: busy_o never rose after a command was queued");
            failures++;
        end
    endtask

    task automatic wait_drained(output logic ok);
        int n;
        for (n = 0; n < 5000 && (ref_q.size() != 0 || busy_o); n++) @(negedge clk_i);
        ok = (ref_q.size() == 0) && !busy_o;
        if (!ok) begin
            $display("Error: queued frames did not all finish on the bus");
            failures++;
        end
    endtask

    task automatic send_frames(logic [6:0] addr, int count);
        write_reg(1'b0, {1'b0, addr});
        for (int i = 0; i < count; i++) write_reg(1'b1, lcg_next() >> 24);
        release_wr();
    endtask

    initial begin
        logic [6:0] other;
        logic       ok;
        int         asserts;
        rst_i = 1'b1;
        wr_en_i = 1'b0;
        wr_sel_i = 1'b0;
        wr_data_i = '0;
        scl_sim_target_i = 1'b1;
        sda_sim_target_i = 1'b1;
        begin : stim
            repeat (10) @(posedge clk_i);
            @(negedge clk_i);
            rst_i = 1'b0;
            check_nack("bus_scl_o", bus_scl_o, 1'b1);
            check_nack("bus_sda_o", bus_sda_o, 1'b1);
            check_nack("busy_o", busy_o, 1'b0);
            check_nack("done_o", done_o, 1'b0);
            check_drops("drop_cnt_o", drop_cnt_o, 8'd0);
            for (int r = 0; r < 3; r++) begin
                send_frames(TB_TARGET_ADDR, 3);
                wait_drained(ok);
                if (!ok) disable stim;
                other = lcg_next() >> 25;
                if (other == TB_TARGET_ADDR) other = other + 7'd1;
                send_frames(other, 2);
                wait_drained(ok);
                if (!ok) disable stim;
            end
            // Burst while the bus is busy with the first frame
            send_frames(TB_TARGET_ADDR, 1);
            wait_busy(ok);
            if (!ok) disable stim;
            for (int i = 0; i < DEPTH + 3; i++) write_reg(1'b1, lcg_next() >> 24);
            release_wr();
            repeat (2) @(negedge clk_i);
            check_drops("drop_cnt_o", drop_cnt_o, drops);
            wait_drained(ok);
            if (!ok) disable stim;
            if (got_q.size() != 0) begin
                $display("Error: frames appeared on the bus that were never queued");
                failures++;
            end
        end
        asserts = i3c_top_inst.xi3c_cmd_fifo.fifo_chk.err_cnt
                  + i3c_top_inst.xi3c_bus_sequencer.seq_chk.err_cnt;
        $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatches, failures, asserts);
        if (mismatches == 0 && failures == 0 && asserts == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+hw
hw/i3c_pkg.sv
hw/i3c_cmd_intake.sv
hw/i3c_cmd_fifo.sv
hw/i3c_bus_sequencer.sv
hw/i3c_top.sv
tests/i3c_chk.sv
tests/i3c_tb.sv
